// File: logic/dcache_pkg.sv
// ------------------------------
// data cache sizes, address split
// and enums, shared by every block
// ------------------------------
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int LINE_W   = 128;
    localparam int OFFSET_W = 4;   // bit 3 picks the word half
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int BANK_W   = 2;   // upper index bits
    localparam int NLINE    = 2 ** INDEX_W;
    localparam int MASK_W   = DATA_W / 8;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_COMPARE    = 3'd1,
        ST_WRITEBACK  = 3'd2,
        ST_ALLOCATE   = 3'd3,
        ST_READIN     = 3'd4,
        ST_WRITEIN    = 3'd5,
        ST_FENCE      = 3'd6,
        ST_FENCE_NEXT = 3'd7
    } cache_state_e;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire

// File: logic/line_store_if.sv
// ------------------------------
// controller to line store link,
// index, write strobes, read line
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface line_store_if;
    import dcache_pkg::*;

    logic [INDEX_W-1:0]  idx;
    logic                we;          // word merge
    logic [LINE_W/8-1:0] wmask_word;  // byte mask already placed in its half
    logic [DATA_W-1:0]   wdata_word;
    logic                fill_we;
    logic [LINE_W-1:0]   fill_line;
    logic [LINE_W-1:0]   rd_line;     // one cycle after idx

    modport ctrl (
        output idx, we, wmask_word, wdata_word, fill_we, fill_line,
        input  rd_line
    );

    modport store (
        input  idx, we, wmask_word, wdata_word, fill_we, fill_line,
        output rd_line
    );

endinterface

`default_nettype wire

// File: logic/flush_counter.sv
// ------------------------------
// fence walk line index, flags
// the last line of the cache
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module flush_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear_i,
    input  logic                          step_i,
    output logic [dcache_pkg::INDEX_W-1:0] idx_o,
    output logic                          last_o
);
    import dcache_pkg::*;

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            idx_o <= '0;
        end else if (step_i) begin
            idx_o <= idx_o + 1'b1;
        end
    end

    assign last_o = (idx_o == INDEX_W'(NLINE - 1));

endmodule

`default_nettype wire

// File: logic/tag_store.sv
// ------------------------------
// valid, dirty and tag arrays,
// combinational hit and victim
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::INDEX_W-1:0] idx_i,
    input  logic [dcache_pkg::TAG_W-1:0]   tag_i,
    input  logic                          fill_i,
    input  logic                          mark_dirty_i,
    input  logic                          clean_i,
    output logic                          hit_o,
    output logic                          valid_o,
    output logic                          dirty_o,
    output logic [dcache_pkg::TAG_W-1:0]   stored_tag_o
);
    import dcache_pkg::*;

    logic [NLINE-1:0] valid_q;
    logic [NLINE-1:0] dirty_q;
    logic [TAG_W-1:0] tag_q [NLINE];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_i) begin
            valid_q[idx_i] <= 1'b1;
            dirty_q[idx_i] <= 1'b0;  // fresh line from memory
        end else if (mark_dirty_i) begin
            dirty_q[idx_i] <= 1'b1;
        end else if (clean_i) begin
            dirty_q[idx_i] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[idx_i] <= tag_i;
        end
    end

    assign valid_o      = valid_q[idx_i];
    assign dirty_o      = dirty_q[idx_i];
    assign stored_tag_o = tag_q[idx_i];
    assign hit_o        = valid_o && (stored_tag_o == tag_i);

endmodule

`default_nettype wire

// File: logic/line_store.sv
// ------------------------------
// four line banks, registered
// read, fill and word merge write
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input logic         clk,
    line_store_if.store ls
);
    import dcache_pkg::*;

    logic [LINE_W-1:0]         bank_q [2**BANK_W];
    logic [BANK_W-1:0]         bank_sel, sel_q;
    logic [INDEX_W-BANK_W-1:0] row;
    logic [LINE_W-1:0]         bit_mask, merged, wr_line;

    assign bank_sel = ls.idx[INDEX_W-1 -: BANK_W];
    assign row      = ls.idx[INDEX_W-BANK_W-1:0];

    always_comb begin
        for (int b = 0; b < LINE_W / 8; b++) begin
            bit_mask[b*8 +: 8] = {8{ls.wmask_word[b]}};
        end
    end

    // rd_line still holds the addressed line during the merge
    assign merged  = ({2{ls.wdata_word}} & bit_mask) | (ls.rd_line & ~bit_mask);
    assign wr_line = ls.fill_we ? ls.fill_line : merged;

    for (genvar g = 0; g < 2**BANK_W; g++) begin : g_bank
        logic [LINE_W-1:0] mem [2**(INDEX_W-BANK_W)];

        always_ff @(posedge clk) begin
            if ((ls.fill_we || ls.we) && (bank_sel == BANK_W'(g))) begin
                mem[row] <= wr_line;
            end
            bank_q[g] <= mem[row];  // read before write
        end
    end

    always_ff @(posedge clk) begin
        sel_q <= bank_sel;
    end

    assign ls.rd_line = bank_q[sel_q];

endmodule

`default_nettype wire

// File: logic/dcache_ctrl.sv
// ------------------------------
// cache FSM for lookup, write-back,
// fill, write merge and fence walk
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cpu_valid_i,
    input  logic                          cpu_we_i,
    input  logic                          fence_i,
    input  logic [dcache_pkg::ADDR_W-1:0]  cpu_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0]  cpu_wdata_i,
    input  logic [dcache_pkg::MASK_W-1:0]  cpu_wmask_i,
    input  logic                          hit_i,
    input  logic                          victim_dirty_i,
    input  logic                          line_valid_i,
    input  logic [dcache_pkg::TAG_W-1:0]   victim_tag_i,
    input  logic                          mem_ready_i,
    input  logic [dcache_pkg::LINE_W-1:0]  mem_rdata_i,
    input  logic [dcache_pkg::INDEX_W-1:0] flush_idx_i,
    input  logic                          flush_last_i,
    line_store_if.ctrl                    ls,
    output logic                          cpu_ready_o,
    output logic [dcache_pkg::DATA_W-1:0]  cpu_rdata_o,
    output logic                          mem_valid_o,
    output dcache_pkg::mem_op_e           mem_op_o,
    output logic [dcache_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic [dcache_pkg::LINE_W-1:0]  mem_wdata_o,
    output logic                          tag_fill_o,
    output logic                          tag_mark_dirty_o,
    output logic                          tag_clean_o,
    output logic [dcache_pkg::INDEX_W-1:0] tag_idx_o,
    output logic                          flush_clear_o,
    output logic                          flush_step_o
);
    import dcache_pkg::*;

    cache_state_e       state_q, state_d;
    logic [INDEX_W-1:0] cpu_idx;
    logic               accept, fence_busy, line_dirty, line_done, mem_req, fill;

    assign cpu_idx    = cpu_addr_i[OFFSET_W +: INDEX_W];
    assign accept     = cpu_valid_i && !cpu_ready_o;  // request still held in ready cycle
    assign fence_busy = (state_q == ST_FENCE) || (state_q == ST_FENCE_NEXT);
    assign line_dirty = line_valid_i && victim_dirty_i;
    assign line_done  = !line_dirty || mem_ready_i;   // fence line needs no write or is written
    assign fill       = (state_q == ST_ALLOCATE) && mem_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = fence_i ? ST_FENCE_NEXT : ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                if (hit_i) begin
                    state_d = ST_READIN;
                end else if (line_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_ALLOCATE;
                end
            end
            ST_WRITEBACK: if (mem_ready_i) state_d = ST_ALLOCATE;
            ST_ALLOCATE:  if (mem_ready_i) state_d = ST_COMPARE;  // look up again
            ST_READIN:    state_d = cpu_we_i ? ST_WRITEIN : ST_IDLE;
            ST_WRITEIN:   state_d = ST_IDLE;
            ST_FENCE_NEXT: state_d = ST_FENCE;                     // wait for rd_line
            ST_FENCE: begin
                if (line_done) begin
                    state_d = flush_last_i ? ST_IDLE : ST_FENCE_NEXT;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            cpu_ready_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            cpu_ready_o <= (state_q == ST_READIN) ||
                           ((state_q == ST_FENCE) && line_done && flush_last_i);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_READIN) begin
            cpu_rdata_o <= cpu_addr_i[OFFSET_W-1] ? ls.rd_line[LINE_W-1 -: DATA_W]
                                                  : ls.rd_line[DATA_W-1:0];
        end
    end

    // memory request held until ready
    assign mem_req = (state_q == ST_WRITEBACK) || (state_q == ST_ALLOCATE) ||
                     ((state_q == ST_FENCE) && line_dirty);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid_o <= 1'b0;
        end else if (mem_ready_i) begin
            mem_valid_o <= 1'b0;
        end else if (mem_req) begin
            mem_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req && !mem_valid_o && !mem_ready_i) begin
            if (state_q == ST_ALLOCATE) begin
                mem_op_o   <= MEM_READ;
                mem_addr_o <= {cpu_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            end else begin
                mem_op_o   <= MEM_WRITE;
                mem_addr_o <= {victim_tag_i, tag_idx_o, {OFFSET_W{1'b0}}};
            end
            mem_wdata_o <= ls.rd_line;
        end
    end

    assign tag_idx_o        = fence_busy ? flush_idx_i : cpu_idx;
    assign tag_fill_o       = fill;
    assign tag_mark_dirty_o = (state_q == ST_WRITEIN);
    assign tag_clean_o      = (state_q == ST_FENCE) && line_dirty && mem_ready_i;
    assign flush_clear_o    = (state_q == ST_IDLE) && accept && fence_i;
    assign flush_step_o     = (state_q == ST_FENCE) && line_done && !flush_last_i;

    assign ls.idx        = tag_idx_o;
    assign ls.we         = (state_q == ST_WRITEIN);
    assign ls.wmask_word = cpu_addr_i[OFFSET_W-1] ? {cpu_wmask_i, {MASK_W{1'b0}}}
                                                  : {{MASK_W{1'b0}}, cpu_wmask_i};
    assign ls.wdata_word = cpu_wdata_i;
    assign ls.fill_we    = fill;
    assign ls.fill_line  = mem_rdata_i;

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
// ------------------------------
// write-back data cache top,
// CPU port on one side, line
// memory port on the other
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cpu_valid_i,
    input  logic                         cpu_we_i,
    input  logic                         fence_i,
    input  logic [dcache_pkg::ADDR_W-1:0] cpu_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] cpu_wdata_i,
    input  logic [dcache_pkg::MASK_W-1:0] cpu_wmask_i,
    output logic                         cpu_ready_o,
    output logic [dcache_pkg::DATA_W-1:0] cpu_rdata_o,
    output logic                         mem_valid_o,
    output dcache_pkg::mem_op_e          mem_op_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [dcache_pkg::LINE_W-1:0] mem_wdata_o,
    input  logic                         mem_ready_i,
    input  logic [dcache_pkg::LINE_W-1:0] mem_rdata_i
);
    import dcache_pkg::*;

    logic               hit, valid, dirty;
    logic [TAG_W-1:0]   stored_tag;
    logic               tag_fill, tag_mark_dirty, tag_clean;
    logic [INDEX_W-1:0] tag_idx, flush_idx;
    logic               flush_clear, flush_step, flush_last;

    line_store_if ls_if ();

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_valid_i      (cpu_valid_i),
        .cpu_we_i         (cpu_we_i),
        .fence_i          (fence_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_wdata_i      (cpu_wdata_i),
        .cpu_wmask_i      (cpu_wmask_i),
        .hit_i            (hit),
        .victim_dirty_i   (dirty),
        .line_valid_i     (valid),
        .victim_tag_i     (stored_tag),
        .mem_ready_i      (mem_ready_i),
        .mem_rdata_i      (mem_rdata_i),
        .flush_idx_i      (flush_idx),
        .flush_last_i     (flush_last),
        .ls               (ls_if.ctrl),
        .cpu_ready_o      (cpu_ready_o),
        .cpu_rdata_o      (cpu_rdata_o),
        .mem_valid_o      (mem_valid_o),
        .mem_op_o         (mem_op_o),
        .mem_addr_o       (mem_addr_o),
        .mem_wdata_o      (mem_wdata_o),
        .tag_fill_o       (tag_fill),
        .tag_mark_dirty_o (tag_mark_dirty),
        .tag_clean_o      (tag_clean),
        .tag_idx_o        (tag_idx),
        .flush_clear_o    (flush_clear),
        .flush_step_o     (flush_step)
    );

    flush_counter u_flush (
        .clk     (clk),
        .rst     (rst),
        .clear_i (flush_clear),
        .step_i  (flush_step),
        .idx_o   (flush_idx),
        .last_o  (flush_last)
    );

    tag_store u_tags (
        .clk          (clk),
        .rst          (rst),
        .idx_i        (tag_idx),
        .tag_i        (cpu_addr_i[ADDR_W-1 -: TAG_W]),
        .fill_i       (tag_fill),
        .mark_dirty_i (tag_mark_dirty),
        .clean_i      (tag_clean),
        .hit_o        (hit),
        .valid_o      (valid),
        .dirty_o      (dirty),
        .stored_tag_o (stored_tag)
    );

    line_store u_lines (
        .clk (clk),
        .ls  (ls_if.store)
    );

endmodule

`default_nettype wire

// File: tb/dcache_assertions.sv
// ------------------------------
// concurrent handshake checks
// bound to dcache_top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic                          cpu_valid_i,
    input logic                          fence_i,
    input logic                          cpu_ready_i,
    input logic                          hit_i,
    input dcache_pkg::cache_state_e      state_i,
    input logic                          mem_valid_i,
    input logic                          mem_ready_i,
    input dcache_pkg::mem_op_e           mem_op_i,
    input logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
    input logic [dcache_pkg::LINE_W-1:0] mem_wdata_i
);
    import dcache_pkg::*;

    int unsigned err_cnt = 0;  // failed assertion count

    ready_single_cycle: assert property (@(posedge clk) disable iff (rst)
        cpu_ready_i |=> !cpu_ready_i)
    else begin
        $error("cpu_ready_o stayed high for two cycles");
        err_cnt++;
    end

    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i) &&
                                        $stable(mem_op_i) && $stable(mem_wdata_i))
    else begin
        $error("memory request changed before mem_ready_i");
        err_cnt++;
    end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !mem_valid_i && !cpu_ready_i)
    else begin
        $error("mem_valid_o or cpu_ready_o high right after reset");
        err_cnt++;
    end

    // read accepted in idle that hits on its first compare
    read_hit_latency: assert property (@(posedge clk) disable iff (rst)
        (state_i == ST_IDLE && cpu_valid_i && !cpu_ready_i && !fence_i)
        ##1 (state_i == ST_COMPARE && hit_i)
        |-> !cpu_ready_i ##1 !cpu_ready_i ##1 cpu_ready_i)
    else begin
        $error("hit did not give cpu_ready_o three cycles after acceptance");
        err_cnt++;
    end

endmodule

bind dcache_top dcache_assertions chk0 (
    .clk         (clk),
    .rst         (rst),
    .cpu_valid_i (cpu_valid_i),
    .fence_i     (fence_i),
    .cpu_ready_i (cpu_ready_o),
    .hit_i       (hit),
    .state_i     (u_ctrl.state_q),
    .mem_valid_i (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_op_i    (mem_op_o),
    .mem_addr_i  (mem_addr_o),
    .mem_wdata_i (mem_wdata_o)
);

`default_nettype wire

// File: tb/dcache_tb.sv
// ------------------------------
// data cache testbench with memory
// model, golden byte model, hit,
// miss, eviction and fence tests
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int CPU_TIMEOUT = 2000;

    logic               clk, rst;
    logic               cpu_valid_i, cpu_we_i, fence_i, cpu_ready_o;
    logic [ADDR_W-1:0]  cpu_addr_i;
    logic [DATA_W-1:0]  cpu_wdata_i, cpu_rdata_o;
    logic [MASK_W-1:0]  cpu_wmask_i;
    logic               mem_valid_o, mem_ready_i;
    mem_op_e            mem_op_o;
    logic [ADDR_W-1:0]  mem_addr_o;
    logic [LINE_W-1:0]  mem_wdata_o, mem_rdata_i;

    logic [31:0]  lfsr_q = 32'h1ab39400;
    bit           slow_mem = 1'b0;
    logic [127:0] mem_lines [logic [31:0]];
    logic [7:0]   golden [logic [31:0]];   // bytes written by the CPU
    mem_op_e      log_op[$];
    logic [31:0]  log_addr[$];
    int           mismatches = 0;
    int           tests_ok = 0;
    int           tests_bad = 0;

    dcache_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic logic [127:0] mem_line(input logic [31:0] adr);
        logic [127:0] v;
        if (mem_lines.exists(adr)) return mem_lines[adr];
        for (int k = 0; k < 4; k++) v[32*k +: 32] = adr + 32'(4 * k);  // address pattern
        return v;
    endfunction

    function automatic logic [7:0] expect_byte(input logic [31:0] adr);
        logic [31:0] w;
        if (golden.exists(adr)) return golden[adr];
        w = {adr[31:2], 2'b00};
        return w[8*adr[1:0] +: 8];
    endfunction

    function automatic logic [63:0] expect_word(input logic [31:0] adr);
        logic [63:0] v;
        for (int i = 0; i < 8; i++) v[8*i +: 8] = expect_byte({adr[31:3], 3'b0} + 32'(i));
        return v;
    endfunction

    function automatic logic [127:0] expect_line(input logic [31:0] adr);
        logic [127:0] v;
        for (int i = 0; i < 16; i++) v[8*i +: 8] = expect_byte({adr[31:4], 4'b0} + 32'(i));
        return v;
    endfunction

    task automatic finish_run(input bit ok);
        if (ok) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic check_val(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_log(input int i, input mem_op_e op, input logic [31:0] adr);
        if (i < log_op.size()) begin
            check_val("memory opcode", log_op[i], op);
            check_val("memory address", log_addr[i], adr);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (mismatches == errs_before) begin
            tests_ok++;
            $display("%s ok", name);
        end else begin
            tests_bad++;
            $display("%s failed with %0d mismatches", name, mismatches - errs_before);
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic cpu_access(input bit we, input bit fence, input logic [31:0] adr,
                              input logic [63:0] d, input logic [7:0] m,
                              output logic [63:0] rdata);
        int n;
        cpu_valid_i = 1'b1;
        cpu_we_i    = we;
        fence_i     = fence;
        cpu_addr_i  = adr;
        cpu_wdata_i = d;
        cpu_wmask_i = m;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_ready_o && n < CPU_TIMEOUT);
        if (!cpu_ready_o) begin
            $display("timeout: cpu_ready_o never came for address %h", adr);
            finish_run(1'b0);
        end else begin
            rdata = cpu_rdata_o;
            @(posedge clk);
            #1;
            cpu_valid_i = 1'b0;
            cpu_we_i    = 1'b0;
            fence_i     = 1'b0;
        end
    endtask

    task automatic read_word(input logic [31:0] adr, output logic [63:0] rdata);
        cpu_access(1'b0, 1'b0, adr, '0, '0, rdata);
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [63:0] d,
                              input logic [7:0] m);
        logic [63:0] unused;
        for (int i = 0; i < 8; i++) begin
            if (m[i]) golden[{adr[31:3], 3'b0} + 32'(i)] = d[8*i +: 8];
        end
        cpu_access(1'b1, 1'b0, adr, d, m, unused);
    endtask

    task automatic run_fence();
        logic [63:0] unused;
        cpu_access(1'b0, 1'b1, '0, '0, '0, unused);
    endtask

    task automatic clear_log();
        log_op.delete();
        log_addr.delete();
    endtask

    task automatic run_suite(input logic [31:0] base, input string sfx);
        logic [31:0]  a, b, c, fbase, adr;
        logic [63:0]  got;
        logic [127:0] ln;
        bit           used [int];
        int           e, n_dirty;
        a     = base + 32'h8;
        b     = a + 32'h400;   // same index with another tag
        c     = base + 32'h800;
        fbase = base + 32'h0001_0000;

        e = mismatches;
        clear_log();
        read_word(a, got);
        check_val("cold read data", got, expect_word(a));
        check_val("cold read memory requests", log_op.size(), 1);
        check_log(0, MEM_READ, base);
        read_word(a, got);
        check_val("repeated read data", got, expect_word(a));
        check_val("repeated read memory requests", log_op.size(), 1);
        report_test({"cold read miss", sfx}, e);

        e = mismatches;
        clear_log();
        write_word(a, take_bits(64), 8'(take_bits(8)));
        read_word(a, got);
        check_val("merged word", got, expect_word(a));
        read_word(base, got);
        check_val("other word of line", got, expect_word(base));
        check_val("write hit memory requests", log_op.size(), 0);
        report_test({"write hit merge", sfx}, e);

        e = mismatches;
        clear_log();
        read_word(b, got);
        check_val("conflict read data", got, expect_word(b));
        check_val("eviction memory requests", log_op.size(), 2);
        check_log(0, MEM_WRITE, base);
        check_log(1, MEM_READ, {b[31:4], 4'b0});
        check_val("written back line", mem_line(base), expect_line(base));
        read_word(a, got);
        check_val("read back after eviction", got, expect_word(a));
        report_test({"dirty eviction", sfx}, e);

        e = mismatches;
        clear_log();
        read_word(c, got);
        check_val("clean conflict data", got, expect_word(c));
        check_val("clean eviction memory requests", log_op.size(), 1);
        check_log(0, MEM_READ, c);
        report_test({"clean eviction", sfx}, e);

        e = mismatches;
        for (int i = 0; i < 6; i++) begin
            adr = fbase + {6'(take_bits(6)), 4'b0} + {1'(take_bits(1)), 3'b0};
            used[int'(adr[9:4])] = 1'b1;
            write_word(adr, take_bits(64), 8'(take_bits(8)));
        end
        n_dirty = used.num();
        clear_log();
        run_fence();
        check_val("fence write-backs", log_op.size(), n_dirty);
        foreach (log_addr[i]) begin
            adr = log_addr[i];
            check_val("fence opcode", log_op[i], MEM_WRITE);
            assert (adr[31:10] == fbase[31:10] && adr[3:0] == 4'h0 &&
                    used.exists(int'(adr[9:4]))) else begin
                $display("[FAIL] %0t fence wrote line %h that was not dirty", $time, adr);
                mismatches++;
            end
            used.delete(int'(adr[9:4]));
        end
        clear_log();
        run_fence();
        check_val("second fence write-backs", log_op.size(), 0);
        n_dirty = 0;
        foreach (golden[ga]) begin
            ln = mem_line({ga[31:4], 4'b0});
            if (ln[8*ga[3:0] +: 8] !== golden[ga]) n_dirty++;
        end
        check_val("memory bytes differing from golden", n_dirty, 0);
        report_test({"fence", sfx}, e);
    endtask

    // memory model answers 1 to 4 cycles after it sees a request
    initial begin : mem_model
        int d;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_valid_o) begin
                d = slow_mem ? 4 : 1 + int'(take_bits(2));
                log_op.push_back(mem_op_o);
                log_addr.push_back(mem_addr_o);
                if (mem_op_o == MEM_WRITE) mem_lines[mem_addr_o] = mem_wdata_o;
                repeat (d) @(posedge clk);
                #1;
                mem_ready_i = 1'b1;
                mem_rdata_i = mem_line(mem_addr_o);
                @(posedge clk);
                #1;
                mem_ready_i = 1'b0;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        cpu_valid_i = 1'b0;
        cpu_we_i    = 1'b0;
        fence_i     = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        cpu_wmask_i = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        run_suite(32'h0001_0000, "");
        slow_mem = 1'b1;  // back-pressure pass
        run_suite(32'h0100_0000, " at max memory delay");
        $display("tests passed %0d, tests failed %0d, assertion failures %0d",
                 tests_ok, tests_bad, dut0.chk0.err_cnt);
        finish_run(tests_bad == 0 && dut0.chk0.err_cnt == 0);
    end

endmodule

`default_nettype wire

// File: tb.f
logic/dcache_pkg.sv
logic/line_store_if.sv
logic/flush_counter.sv
logic/tag_store.sv
logic/line_store.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tb/dcache_assertions.sv
tb/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/line_store_if.sv
      - logic/flush_counter.sv
      - logic/tag_store.sv
      - logic/line_store.sv
      - logic/dcache_ctrl.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - tb/dcache_assertions.sv
      - tb/dcache_tb.sv
